//--- Makefile
# Verilator build and run of the VGA output stage testbench

SRCS = hdl/vgaPkg.sv hdl/scanTimer.sv hdl/colorPipe.sv hdl/ditherOut.sv hdl/vgaTop.sv \
	tb/vgaTb.sv tb/vgaChecks.svh

.PHONY: run clean

run: obj_dir/VvgaTb
	@out="$$(./obj_dir/VvgaTb)"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

# rebuilt only when a source or the file list changes
obj_dir/VvgaTb: vlog.f $(SRCS)
	verilator --binary --timing --top-module vgaTb -f vlog.f -o VvgaTb

clean:
	rm -rf obj_dir

//--- hdl/colorPipe.sv
`timescale 1ns/1ps

module colorPipe
	import vgaPkg::*;
(
	input logic clock,
	input logic reset,
	input component pixCy,
	input component pixCu,
	input component pixCv,
	input logic rgbMode,
	input logic active,
	input logic border,
	input logic hsync,
	input logic vsync,
	input fieldCount field,
	input pixelCoord pixPosX,
	input pixelCoord pixPosY,
	output component chanR,
	output component chanG,
	output component chanB,
	output logic activeD,
	output logic borderD,
	output logic hsyncD,
	output logic vsyncD,
	output fieldCount fieldD,
	output bayerIndex index
);

	// flag bundle is {active, border, hsync, vsync}
	// slot 0 covers the framebuffer fetch cycle
	logic [3:0] flagPipe [0:2];
	logic [1:0] xPipe [0:2];
	logic [1:0] yPipe [0:2];
	fieldCount fieldPipe [0:2];

	// chroma offset, none for direct RGB
	colorWide chromaBias;

	// stage 1 sample
	colorWide yS1;
	colorWide uS1;
	colorWide vS1;
	logic modeS1;

	// stage 2, green and delayed chroma
	colorWide gS2;
	colorWide uS2;
	colorWide vS2;
	logic modeS2;

	// saturate to 0..255
	function automatic component clampByte(input colorWide value);
		component result;
		if (value < 0)
			result = '0;
		else if (value > 16'sd255)
			result = 8'hff;
		else
			result = value[7:0];
		return result;
	endfunction

	assign chromaBias = rgbMode ? 16'sd0 : 16'sd128;

	// timing flags, stepped with the pixel
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			flagPipe[0] <= '0;
			flagPipe[1] <= '0;
			flagPipe[2] <= '0;
			{activeD, borderD, hsyncD, vsyncD} <= '0;
		end
		else
		begin
			flagPipe[0] <= {active, border, hsync, vsync};
			flagPipe[1] <= flagPipe[0];
			flagPipe[2] <= flagPipe[1];
			{activeD, borderD, hsyncD, vsyncD} <= flagPipe[2];
		end
	end

	// conversion datapath and position bits
	always_ff @(posedge clock)
	begin
		xPipe[0] <= pixPosX[1:0];
		yPipe[0] <= pixPosY[1:0];
		fieldPipe[0] <= field;
		xPipe[1] <= xPipe[0];
		yPipe[1] <= yPipe[0];
		fieldPipe[1] <= fieldPipe[0];
		xPipe[2] <= xPipe[1];
		yPipe[2] <= yPipe[1];
		fieldPipe[2] <= fieldPipe[1];

		// pixel arrives one cycle after its position
		yS1 <= $signed({8'h00, pixCy});
		uS1 <= $signed({8'h00, pixCu}) - chromaBias;
		vS1 <= $signed({8'h00, pixCv}) - chromaBias;
		modeS1 <= rgbMode;

		// shift-only matrix, G = Y - U'/2 - V'/2
		gS2 <= modeS1 ? yS1 : yS1 - (uS1 >>> 1) - (vS1 >>> 1);
		uS2 <= uS1;
		vS2 <= vS1;
		modeS2 <= modeS1;

		// R = G + 2V', B = G + 2U'; bypass takes V and U as they are
		chanR <= clampByte(modeS2 ? vS2 : gS2 + (vS2 <<< 1));
		chanG <= clampByte(gS2);
		chanB <= clampByte(modeS2 ? uS2 : gS2 + (uS2 <<< 1));

		// pattern shifts each field
		index <= {yPipe[2] ^ fieldPipe[2], xPipe[2] ^ fieldPipe[2]};
		fieldD <= fieldPipe[2];
	end

endmodule

//--- hdl/ditherOut.sv
`timescale 1ns/1ps

module ditherOut
	import vgaPkg::*;
#(
	parameter component borderLevel = 76
)
(
	input logic clock,
	input logic reset,
	input component chanR,
	input component chanG,
	input component chanB,
	input logic activeD,
	input logic borderD,
	input logic hsyncD,
	input logic vsyncD,
	input bayerIndex index,
	output dacLevel red,
	output dacLevel green,
	output dacLevel blue,
	output logic hsyncN,
	output logic vsyncN
);

	// 8-bit level per channel before dithering
	component levelR;
	component levelG;
	component levelB;

	// map 0..255 into the DAC window 80..239
	function automatic component scaleLevel(input component value);
		logic [15:0] scaled;
		scaled = {8'h00, value} * 16'd160 + 16'd20480;
		return scaled[15:8];
	endfunction

	// classic 4x4 Bayer thresholds, row-major
	function automatic logic [3:0] bayerThreshold(input bayerIndex ix);
		logic [3:0] th;
		case (ix)
			4'd0: th = 4'd0;
			4'd1: th = 4'd8;
			4'd2: th = 4'd2;
			4'd3: th = 4'd10;
			4'd4: th = 4'd12;
			4'd5: th = 4'd4;
			4'd6: th = 4'd14;
			4'd7: th = 4'd6;
			4'd8: th = 4'd3;
			4'd9: th = 4'd11;
			4'd10: th = 4'd1;
			4'd11: th = 4'd9;
			4'd12: th = 4'd15;
			4'd13: th = 4'd7;
			4'd14: th = 4'd13;
			default: th = 4'd5;
		endcase
		return th;
	endfunction

	// top nibble, bumped when the low nibble beats the threshold
	function automatic dacLevel ditherNibble(input component level, input logic enable,
		input bayerIndex ix);
		dacLevel top;
		logic roundUp;
		top = level[7:4];
		// no bump past full scale
		roundUp = enable && (level[3:0] > bayerThreshold(ix)) && (top != 4'hf);
		return roundUp ? top + 4'd1 : top;
	endfunction

	// pick the region level
	always_comb
	begin
		if (activeD)
		begin
			levelR = scaleLevel(chanR);
			levelG = scaleLevel(chanG);
			levelB = scaleLevel(chanB);
		end
		else if (borderD)
		begin
			levelR = borderLevel;
			levelG = borderLevel;
			levelB = borderLevel;
		end
		else
		begin
			// hsync and sync-row blank
			levelR = '0;
			levelG = '0;
			levelB = '0;
		end
	end

	// output registers, syncs are active low
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hsyncN <= 1'b1;
			vsyncN <= 1'b1;
		end
		else
		begin
			// only picture pixels get dithered
			red <= ditherNibble(levelR, activeD, index);
			green <= ditherNibble(levelG, activeD, index);
			blue <= ditherNibble(levelB, activeD, index);
			hsyncN <= !hsyncD;
			vsyncN <= !vsyncD;
		end
	end

endmodule

//--- hdl/scanTimer.sv
`timescale 1ns/1ps

module scanTimer
	import vgaPkg::*;
#(
	parameter pixelCoord lineLength = 800,
	parameter pixelCoord activeStart = 48,
	parameter pixelCoord activeEnd = 688,
	parameter pixelCoord hsyncStart = 704,
	parameter pixelCoord syncRows = 2,
	parameter pixelCoord scanRows = 480
)
(
	input logic clock,
	input logic reset,
	output logic active,
	output logic border,
	output logic hsync,
	output logic vsync,
	output fieldCount field,
	output pixelCoord pixPosX,
	output pixelCoord pixPosY,
	output logic pixLineOdd
);

	// last index of each counter range
	localparam pixelCoord lastPixIdx = pixelCoord'(lineLength - 1);
	localparam pixelCoord lastSyncRow = pixelCoord'(syncRows - 1);
	localparam pixelCoord lastScanRow = pixelCoord'(scanRows - 1);

	// position within the frame
	pixelCoord pixCount;
	pixelCoord rowCount;
	scanState state;
	fieldCount fieldReg;

	// decoded from the current counters
	logic lastPixel;
	logic lastRow;
	logic inScan;
	logic inActive;
	logic inHsync;

	assign lastPixel = (pixCount == lastPixIdx);
	assign inScan = (state == stateScan);

	// row limit depends on which part of the frame we are in
	assign lastRow = inScan ? (rowCount == lastScanRow) : (rowCount == lastSyncRow);

	// active window only exists on picture rows
	assign inActive = inScan && (pixCount >= activeStart) && (pixCount < activeEnd);

	// hsync tail runs to the end of every line
	assign inHsync = (pixCount >= hsyncStart);

	// pixel, row and field counters
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pixCount <= '0;
			rowCount <= '0;
			state <= stateSync;
			fieldReg <= '0;
		end
		else if (lastPixel)
		begin
			pixCount <= '0;
			if (lastRow)
			begin
				rowCount <= '0;
				if (state == stateSync)
				begin
					// sync rows done, picture starts at row 0
					state <= stateScan;
				end
				else
				begin
					// frame done, back to vsync
					state <= stateSync;
					fieldReg <= fieldReg + 1'b1;
				end
			end
			else
			begin
				rowCount <= rowCount + 1'b1;
			end
		end
		else
		begin
			pixCount <= pixCount + 1'b1;
		end
	end

	// registered region flags and position
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			active <= 1'b0;
			border <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			field <= '0;
			pixPosX <= '0;
			pixPosY <= '0;
			pixLineOdd <= 1'b0;
		end
		else
		begin
			active <= inActive;
			// border is whatever is left of a picture row
			border <= inScan && !inActive && !inHsync;
			hsync <= inHsync;
			// whole sync rows held low at the output
			vsync <= !inScan;
			field <= fieldReg;
			// wraps negative before the active window
			pixPosX <= pixCount - activeStart;
			// row index only meaningful on picture rows
			pixPosY <= inScan ? rowCount : '0;
			pixLineOdd <= inScan && rowCount[0];
		end
	end

endmodule

//--- hdl/vgaPkg.sv
package vgaPkg;

	// counter values, pixel positions and timing limits
	typedef logic [11:0] pixelCoord;

	// one 8-bit color sample, also a scaled DAC level
	typedef logic [7:0] component;

	// signed working width for the YUV matrix
	// wide enough for G + 2V' before clamping
	typedef logic signed [15:0] colorWide;

	// per-channel drive into the 4-bit resistor DAC
	typedef logic [3:0] dacLevel;

	// row-major index into the 4x4 ordered dither matrix
	// upper pair is the row bits, lower pair the column bits
	typedef logic [3:0] bayerIndex;

	// frame counter, rotates the dither pattern
	typedef logic [1:0] fieldCount;

	// scan timer states
	// stateSync covers the vsync rows at the top of the frame
	// stateScan covers the picture rows
	typedef enum logic
	{
		stateSync,
		stateScan
	} scanState;

endpackage

//--- hdl/vgaTop.sv
`timescale 1ns/1ps

module vgaTop
	import vgaPkg::*;
#(
	parameter pixelCoord lineLength = 800,
	parameter pixelCoord activeStart = 48,
	parameter pixelCoord activeEnd = 688,
	parameter pixelCoord hsyncStart = 704,
	parameter pixelCoord syncRows = 2,
	parameter pixelCoord scanRows = 480,
	parameter component borderLevel = 76
)
(
	input logic clock,
	input logic reset,
	input component pixCy,
	input component pixCu,
	input component pixCv,
	input logic rgbMode,
	output dacLevel red,
	output dacLevel green,
	output dacLevel blue,
	output logic hsyncN,
	output logic vsyncN,
	output pixelCoord pixPosX,
	output pixelCoord pixPosY,
	output logic pixLineOdd
);

	// timer to color pipe
	logic active;
	logic border;
	logic hsync;
	logic vsync;
	fieldCount field;

	// color pipe to dither stage
	component chanR;
	component chanG;
	component chanB;
	logic activeD;
	logic borderD;
	logic hsyncD;
	logic vsyncD;
	bayerIndex index;

	// produces positions and region flags
	scanTimer #(
		.lineLength(lineLength),
		.activeStart(activeStart),
		.activeEnd(activeEnd),
		.hsyncStart(hsyncStart),
		.syncRows(syncRows),
		.scanRows(scanRows)
	) timer (
		.clock(clock),
		.reset(reset),
		.active(active),
		.border(border),
		.hsync(hsync),
		.vsync(vsync),
		.field(field),
		.pixPosX(pixPosX),
		.pixPosY(pixPosY),
		.pixLineOdd(pixLineOdd)
	);

	// delayed field is only for probing, the index already carries it
	colorPipe pipe (
		.clock(clock),
		.reset(reset),
		.pixCy(pixCy),
		.pixCu(pixCu),
		.pixCv(pixCv),
		.rgbMode(rgbMode),
		.active(active),
		.border(border),
		.hsync(hsync),
		.vsync(vsync),
		.field(field),
		.pixPosX(pixPosX),
		.pixPosY(pixPosY),
		.chanR(chanR),
		.chanG(chanG),
		.chanB(chanB),
		.activeD(activeD),
		.borderD(borderD),
		.hsyncD(hsyncD),
		.vsyncD(vsyncD),
		.fieldD(),
		.index(index)
	);

	ditherOut #(
		.borderLevel(borderLevel)
	) dither (
		.clock(clock),
		.reset(reset),
		.chanR(chanR),
		.chanG(chanG),
		.chanB(chanB),
		.activeD(activeD),
		.borderD(borderD),
		.hsyncD(hsyncD),
		.vsyncD(vsyncD),
		.index(index),
		.red(red),
		.green(green),
		.blue(blue),
		.hsyncN(hsyncN),
		.vsyncN(vsyncN)
	);

endmodule

//--- tb/vgaChecks.svh
`ifndef VGA_CHECKS_SVH
`define VGA_CHECKS_SVH

// compare tasks included inside the testbench module
// types come from the package import of vgaTb

// print the reason and end the run
task automatic stopWithError(input string why);
	$display("%s", why);
	$display("FAIL: see errors above");
	$fatal(1, "stopped at first error");
endtask

// one 4-bit DAC channel
task automatic checkLevel(input dacLevel got, input dacLevel want, input string what);
	if (got !== want)
		stopWithError($sformatf("[FAIL] time %0t: %s is %0d, expected %0d",
			$time, what, got, want));
endtask

// single-bit outputs such as the sync pins and the line parity
task automatic checkSync(input logic got, input logic want, input string what);
	if (got !== want)
		stopWithError($sformatf("[FAIL] time %0t: %s is %b, expected %b",
			$time, what, got, want));
endtask

// pixel position outputs
task automatic checkCoord(input pixelCoord got, input pixelCoord want, input string what);
	if (got !== want)
		stopWithError($sformatf("[FAIL] time %0t: %s is %0d, expected %0d",
			$time, what, got, want));
endtask

`endif

//--- tb/vgaTb.sv
`timescale 1ns/1ps

module vgaTb
	import vgaPkg::*;
();

	// tiny raster of 24 x 8 = 192 cycles per frame
	localparam int lineLength = 24;
	localparam int activeStart = 4;
	localparam int activeEnd = 20;
	localparam int hsyncStart = 21;
	localparam int syncRows = 2;
	localparam int scanRows = 6;
	localparam int borderLevel = 76;
	localparam int frameCycles = lineLength * (syncRows + scanRows);
	localparam int tableSize = 8;
	// table frames plus four more holding the last entry
	localparam int frameTotal = tableSize + 4;
	localparam int timeoutLimit = (tableSize + 2) * frameCycles * 2;

	logic clock;
	logic reset;
	component pixCy;
	component pixCu;
	component pixCv;
	logic rgbMode;
	dacLevel red;
	dacLevel green;
	dacLevel blue;
	logic hsyncN;
	logic vsyncN;
	pixelCoord pixPosX;
	pixelCoord pixPosY;
	logic pixLineOdd;

	// one frame of stimulus with its hand-worked 8-bit DAC levels
	typedef struct packed {
		logic rgbMode;
		component y;
		component u;
		component v;
		component expR;
		component expG;
		component expB;
	} stimEntry;

	// what the outputs should show for one timer position
	typedef struct packed {
		logic active;
		logic border;
		logic hsync;
		logic vsync;
		bayerIndex index;
		component levR;
		component levG;
		component levB;
	} expectRecord;

	stimEntry stimTable [0:tableSize-1];
	stimEntry current;
	// covers the 5-cycle lag from position to pins
	expectRecord history [$];

	// row-major 4x4 ordered dither thresholds
	int bayerTable [0:15] = '{0, 8, 2, 10, 12, 4, 14, 6, 3, 11, 1, 9, 15, 7, 13, 5};

	// model of the scan counters
	int mPix;
	int mRow;
	bit mScan;
	int mField;
	int frameNo;
	int cycleCount = 0;

	`include "vgaChecks.svh"

	vgaTop #(
		.lineLength(pixelCoord'(lineLength)),
		.activeStart(pixelCoord'(activeStart)),
		.activeEnd(pixelCoord'(activeEnd)),
		.hsyncStart(pixelCoord'(hsyncStart)),
		.syncRows(pixelCoord'(syncRows)),
		.scanRows(pixelCoord'(scanRows)),
		.borderLevel(component'(borderLevel))
	) uut (
		.clock(clock),
		.reset(reset),
		.pixCy(pixCy),
		.pixCu(pixCu),
		.pixCv(pixCv),
		.rgbMode(rgbMode),
		.red(red),
		.green(green),
		.blue(blue),
		.hsyncN(hsyncN),
		.vsyncN(vsyncN),
		.pixPosX(pixPosX),
		.pixPosY(pixPosY),
		.pixLineOdd(pixLineOdd)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// hard stop well past the expected run length
	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutLimit)
			stopWithError($sformatf("timeout: the run did not finish within %0d cycles",
				timeoutLimit));
	end

	// top nibble plus one when the low nibble beats the threshold
	function automatic dacLevel expectedNibble(input int level, input bit dithered,
		input int ix);
		int top;
		top = level / 16;
		if (dithered && (level % 16) > bayerTable[ix] && top < 15)
			top = top + 1;
		return dacLevel'(top);
	endfunction

	// drive one table entry onto the frame source pins
	task automatic applyEntry(input int n);
		current = stimTable[n];
		rgbMode = current.rgbMode;
		pixCy = current.y;
		pixCu = current.u;
		pixCv = current.v;
	endtask

	// pins against a record from five cycles back
	task automatic checkOutputs(input expectRecord rec);
		int levR;
		int levG;
		int levB;
		if (rec.active)
		begin
			levR = int'(rec.levR);
			levG = int'(rec.levG);
			levB = int'(rec.levB);
		end
		else if (rec.border)
		begin
			levR = borderLevel;
			levG = borderLevel;
			levB = borderLevel;
		end
		else
		begin
			// hsync and sync-row blank
			levR = 0;
			levG = 0;
			levB = 0;
		end
		checkSync(hsyncN, !rec.hsync, "hsyncN");
		checkSync(vsyncN, !rec.vsync, "vsyncN");
		checkLevel(red, expectedNibble(levR, rec.active, int'(rec.index)), "red");
		checkLevel(green, expectedNibble(levG, rec.active, int'(rec.index)), "green");
		checkLevel(blue, expectedNibble(levB, rec.active, int'(rec.index)), "blue");
	endtask

	// check position and pins for one clock and step the model
	task automatic runCycle();
		pixelCoord expX;
		pixelCoord expY;
		logic expOdd;
		fieldCount f;
		bit inActive;
		bit inHsync;
		expectRecord rec;
		@(negedge clock);
		// new entry at the top of each frame inside the sync rows
		if (!mScan && mRow == 0 && mPix == 0)
		begin
			applyEntry(frameNo < tableSize ? frameNo : tableSize - 1);
			frameNo++;
		end
		expX = pixelCoord'(mPix - activeStart);
		expY = pixelCoord'(mScan ? mRow : 0);
		expOdd = mScan && (mRow % 2 == 1);
		checkCoord(pixPosX, expX, "pixPosX");
		checkCoord(pixPosY, expY, "pixPosY");
		checkSync(pixLineOdd, expOdd, "pixLineOdd");
		inActive = mScan && mPix >= activeStart && mPix < activeEnd;
		inHsync = mPix >= hsyncStart;
		f = fieldCount'(mField);
		rec.active = inActive;
		rec.border = mScan && !inActive && !inHsync;
		rec.hsync = inHsync;
		rec.vsync = !mScan;
		// dither row and column both rotate with the field
		rec.index = {expY[1:0] ^ f, expX[1:0] ^ f};
		rec.levR = current.expR;
		rec.levG = current.expG;
		rec.levB = current.expB;
		history.push_back(rec);
		checkOutputs(history.pop_front());
		// advance pixel, row, state and field
		if (mPix == lineLength - 1)
		begin
			mPix = 0;
			if (mRow == (mScan ? scanRows : syncRows) - 1)
			begin
				mRow = 0;
				if (mScan)
					mField = (mField + 1) % 4;
				mScan = !mScan;
			end
			else
				mRow++;
		end
		else
			mPix++;
	endtask

	initial
	begin
		// levels are 80 + floor(5c/8) of the clamped channel
		// grey with all channels at 128
		stimTable[0] = '{1'b0, 8'd128, 8'd128, 8'd128, 8'd160, 8'd160, 8'd160};
		// R = 137 + 254 clamps high
		stimTable[1] = '{1'b0, 8'd200, 8'd128, 8'd255, 8'd239, 8'd165, 8'd165};
		// R = 80 - 256 clamps low
		stimTable[2] = '{1'b0, 8'd16, 8'd128, 8'd0, 8'd80, 8'd130, 8'd130};
		// G = -13 clamps low and B = 241
		stimTable[3] = '{1'b0, 8'd50, 8'd255, 8'd128, 8'd80, 8'd80, 8'd230};
		// G = 363 clamps high while R = B = 107
		stimTable[4] = '{1'b0, 8'd235, 8'd0, 8'd0, 8'd146, 8'd239, 8'd146};
		// odd negative U' halves to -64
		stimTable[5] = '{1'b0, 8'd100, 8'd1, 8'd200, 8'd239, 8'd160, 8'd80};
		// direct RGB passes V to R and Y to G and U to B
		stimTable[6] = '{1'b1, 8'd64, 8'd255, 8'd0, 8'd80, 8'd120, 8'd239};
		stimTable[7] = '{1'b1, 8'd200, 8'd77, 8'd13, 8'd88, 8'd205, 8'd128};
		reset = 1'b1;
		mPix = 0;
		mRow = 0;
		mScan = 1'b0;
		mField = 0;
		frameNo = 0;
		applyEntry(0);
		// pipeline holds idle values for the first five cycles
		repeat (5) history.push_back(expectRecord'(0));
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		checkSync(hsyncN, 1'b1, "hsyncN after reset");
		checkSync(vsyncN, 1'b1, "vsyncN after reset");
		checkLevel(red, 4'd0, "red after reset");
		checkLevel(green, 4'd0, "green after reset");
		checkLevel(blue, 4'd0, "blue after reset");
		// a few extra cycles drain the last picture row
		repeat (frameTotal * frameCycles + 8) runCycle();
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+tb
hdl/vgaPkg.sv
hdl/scanTimer.sv
hdl/colorPipe.sv
hdl/ditherOut.sv
hdl/vgaTop.sv
tb/vgaTb.sv
